/* crossbar.sv */
`include "noc_defs.svh"

module crossbar
	import noc_flit_pkg::*;
	import noc_arb_pkg::*;
(
	input  logic              clk,
	input  logic              rst,
	input  flit_t             head_flit [`N_IN],
	input  logic [`N_OUT-1:0] out_go,
	input  osel_t             out_sel,
	output logic [`N_OUT-1:0] out_valid,
	output flit_t             out_flit [`N_OUT]
);

	flit_t mux_flit [`N_OUT];

	// one mux per output, steered by the grant
	always_comb begin
		for (int o = 0; o < `N_OUT; o++) begin
			mux_flit[o] = head_flit[out_sel[o]];
		end
	end

	// valid strobes
	always_ff @(posedge clk) begin
		if (rst) begin
			out_valid <= '0;
		end else begin
			out_valid <= out_go;
		end
	end

	// flit registers, loaded only on a grant
	always_ff @(posedge clk) begin
		for (int o = 0; o < `N_OUT; o++) begin
			if (out_go[o]) begin
				out_flit[o] <= mux_flit[o];
			end
		end
	end

endmodule

/* flist.f */
+incdir+.
noc_flit_pkg.sv
noc_arb_pkg.sv
route_comp.sv
input_fifo.sv
switch_ctrl.sv
crossbar.sv
noc_router.sv
noc_router_assert.sv
noc_router_tb.sv

/* input_fifo.sv */
`include "noc_defs.svh"

module input_fifo
	import noc_flit_pkg::*;
(
	input  logic  clk,
	input  logic  rst,
	input  logic  wr,
	input  flit_t wr_flit,
	input  dir_e  wr_dir,
	input  logic  pop,
	output logic  head_valid,
	output flit_t head_flit,
	output dir_e  head_dir,
	output logic  ready
);

	localparam int ptr_w = $clog2(`FIFO_DEPTH);
	localparam logic [ptr_w-1:0] last_slot = ptr_w'(`FIFO_DEPTH - 1);

	flit_t mem_flit [`FIFO_DEPTH];
	dir_e  mem_dir [`FIFO_DEPTH];

	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	// one extra bit so a full buffer is countable
	logic [ptr_w:0]   count;
	logic             do_wr;
	logic             do_pop;

	assign do_pop = pop && head_valid;
	// write dropped only if truly full and nothing leaves
	assign do_wr  = wr && ((count < `FIFO_DEPTH) || do_pop);

	assign head_valid = (count != '0);
	assign head_flit  = mem_flit[rd_ptr];
	assign head_dir   = mem_dir[rd_ptr];
	// one slot kept back for the flit still in route_comp
	assign ready      = (count < (`FIFO_DEPTH - 1));

	// storage
	always_ff @(posedge clk) begin
		if (do_wr) begin
			mem_flit[wr_ptr] <= wr_flit;
			mem_dir[wr_ptr]  <= wr_dir;
		end
	end

	// pointers and occupancy
	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr) begin
				wr_ptr <= (wr_ptr == last_slot) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == last_slot) ? '0 : rd_ptr + 1'b1;
			end
			case ({do_wr, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

/* noc_arb_pkg.sv */
`include "noc_defs.svh"

package noc_arb_pkg;

	// index of one input port
	typedef logic [`PORT_IDX_W-1:0] port_idx_t;

	// one bit per input
	typedef logic [`N_IN-1:0] req_vec_t;
	typedef logic [`N_IN-1:0] gnt_vec_t;

	// winning input for each output
	typedef port_idx_t [`N_OUT-1:0] osel_t;

endpackage

/* noc_defs.svh */
`ifndef NOC_DEFS_SVH
`define NOC_DEFS_SVH

////////////////////////////////////////////////////////////////////////
// flit field layout, lsb first
////////////////////////////////////////////////////////////////////////

`define PAYLOAD_POS 0
`define PAYLOAD_W 32
`define OP_POS 32
`define OP_W 4
`define ALG_TYPE_POS 36
`define ALG_TYPE_W 2
// tag, context and rank are narrowed so the flit fits in 72 bits
`define TAG_POS 38
`define TAG_W 6
`define CONTEXT_ID_POS 44
`define CONTEXT_ID_W 4
`define RANK_POS 48
`define RANK_W 5

// every coordinate field is the same width
`define COORD_W 3
`define SRC_X_POS 53
`define SRC_X_W `COORD_W
`define SRC_Y_POS 56
`define SRC_Y_W `COORD_W
`define SRC_Z_POS 59
`define SRC_Z_W `COORD_W
`define DST_X_POS 62
`define DST_X_W `COORD_W
`define DST_Y_POS 65
`define DST_Y_W `COORD_W
`define DST_Z_POS 68
`define DST_Z_W `COORD_W

// valid flag sits in the top bit
`define VALID_POS 71
`define FLIT_W 72

////////////////////////////////////////////////////////////////////////
// torus and router sizes
////////////////////////////////////////////////////////////////////////

`define XSIZE 4
`define YSIZE 4
`define ZSIZE 4
`define FIFO_DEPTH 4
`define N_IN 7
`define N_OUT 7
// enough bits to name any input
`define PORT_IDX_W 3

`endif

/* noc_flit_pkg.sv */
`include "noc_defs.svh"

package noc_flit_pkg;

	// whole flit as one vector
	// fields picked out with the *_POS / *_W macros
	typedef logic [`FLIT_W-1:0] flit_t;

	// one torus coordinate
	typedef logic [`COORD_W-1:0] coord_t;

	// port directions
	// inject only ever appears on the input side
	// outputs are numbered direction minus one
	typedef enum logic [2:0] {
		dir_inject = 3'd0,
		dir_xpos   = 3'd1,
		dir_ypos   = 3'd2,
		dir_zpos   = 3'd3,
		dir_xneg   = 3'd4,
		dir_yneg   = 3'd5,
		dir_zneg   = 3'd6,
		dir_eject  = 3'd7
	} dir_e;

endpackage

/* noc_router.sv */
`include "noc_defs.svh"

module noc_router
	import noc_flit_pkg::*;
#(
	parameter int cur_x = 0,
	parameter int cur_y = 0,
	parameter int cur_z = 0
) (
	input  logic              clk,
	input  logic              rst,
	input  logic [`N_IN-1:0]  in_valid,
	input  flit_t             in_flit [`N_IN],
	output logic [`N_IN-1:0]  in_ready,
	output logic [`N_OUT-1:0] out_valid,
	output flit_t             out_flit [`N_OUT]
);

	logic [`N_IN-1:0] accept;
	// route stage outputs
	logic [`N_IN-1:0] rc_valid;
	flit_t            rc_flit [`N_IN];
	dir_e             rc_dir [`N_IN];
	// fifo heads
	logic [`N_IN-1:0] head_valid;
	flit_t            head_flit [`N_IN];
	dir_e             head_dir [`N_IN];
	logic [`N_IN-1:0] pop;
	// allocation results
	logic [`N_OUT-1:0]                  out_go;
	logic [`N_OUT-1:0][`PORT_IDX_W-1:0] out_sel;

	assign accept = in_valid & in_ready;

	////////////////////////////////////////////////////////////////////////
	// input lanes, route stage then fifo
	////////////////////////////////////////////////////////////////////////

	for (genvar i = 0; i < `N_IN; i++) begin : g_lane
		route_comp #(
			.cur_x(cur_x),
			.cur_y(cur_y),
			.cur_z(cur_z)
		) i_rc (
			.clk            (clk),
			.rst            (rst),
			.flit_valid     (accept[i]),
			.flit_in        (in_flit[i]),
			.flit_valid_out (rc_valid[i]),
			.flit_out       (rc_flit[i]),
			.dir_out        (rc_dir[i])
		);

		input_fifo i_fifo (
			.clk        (clk),
			.rst        (rst),
			.wr         (rc_valid[i]),
			.wr_flit    (rc_flit[i]),
			.wr_dir     (rc_dir[i]),
			.pop        (pop[i]),
			.head_valid (head_valid[i]),
			.head_flit  (head_flit[i]),
			.head_dir   (head_dir[i]),
			.ready      (in_ready[i])
		);
	end

	////////////////////////////////////////////////////////////////////////
	// switch allocation and output stage
	////////////////////////////////////////////////////////////////////////

	switch_ctrl i_ctrl (
		.clk        (clk),
		.rst        (rst),
		.head_valid (head_valid),
		.head_dir   (head_dir),
		.pop        (pop),
		.out_go     (out_go),
		.out_sel    (out_sel)
	);

	crossbar i_xbar (
		.clk       (clk),
		.rst       (rst),
		.head_flit (head_flit),
		.out_go    (out_go),
		.out_sel   (out_sel),
		.out_valid (out_valid),
		.out_flit  (out_flit)
	);

endmodule

/* noc_router_assert.sv */
`include "noc_defs.svh"

module noc_router_assert
	import noc_flit_pkg::*;
#(
	parameter int cur_x = 0,
	parameter int cur_y = 0,
	parameter int cur_z = 0
) (
	input logic              clk,
	input logic              rst,
	input logic [`N_IN-1:0]  in_valid,
	input flit_t             in_flit [`N_IN],
	input logic [`N_IN-1:0]  in_ready,
	input logic [`N_OUT-1:0] out_valid,
	input flit_t             out_flit [`N_OUT]
);

	localparam int qd = 8;

	int fail_cnt = 0;
	int cyc;
	// flits accepted but not yet seen at an output, oldest first
	dir_e q_dir [`N_IN][qd];
	int   q_cyc [`N_IN][qd];
	int   q_head [`N_IN];
	int   q_cnt [`N_IN];
	// per output history
	int   last_seq [`N_IN][`N_OUT];
	int   last_src [`N_OUT];
	int   run_len [`N_OUT];
	logic [`N_IN-1:0]  popped;
	logic [`N_OUT-1:0] in_order;
	logic [`N_OUT-1:0] rival;

	// sending input sits in payload bits 30:28
	function automatic int src_of(input flit_t f);
		return int'(f[30:28]);
	endfunction

	// reference route, short way round each ring, ties positive
	function automatic dir_e expect_dir(input flit_t f);
		int hx;
		int hy;
		int hz;
		hx = (int'(f[`DST_X_POS +: `COORD_W]) + `XSIZE - cur_x) % `XSIZE;
		hy = (int'(f[`DST_Y_POS +: `COORD_W]) + `YSIZE - cur_y) % `YSIZE;
		hz = (int'(f[`DST_Z_POS +: `COORD_W]) + `ZSIZE - cur_z) % `ZSIZE;
		if (hx != 0) begin
			return (2 * hx <= `XSIZE) ? dir_xpos : dir_xneg;
		end
		if (hy != 0) begin
			return (2 * hy <= `YSIZE) ? dir_ypos : dir_yneg;
		end
		if (hz != 0) begin
			return (2 * hz <= `ZSIZE) ? dir_zpos : dir_zneg;
		end
		return dir_eject;
	endfunction

	function automatic void flag(input string what);
		fail_cnt++;
		$error("FAILED %0t %s", $time, what);
	endfunction

	//////////////////////////////////////////////////////////////////////
	// bookkeeping
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		popped = '0;
		for (int o = 0; o < `N_OUT; o++) begin
			if (out_valid[o]) begin
				popped[src_of(out_flit[o])] = 1'b1;
			end
			in_order[o] = int'(out_flit[o][15:0]) > last_seq[src_of(out_flit[o])][o];
			// another input whose oldest flit waits at a fifo head for this output
			rival[o] = 1'b0;
			for (int j = 0; j < `N_IN; j++) begin
				if (j != last_src[o] && q_cnt[j] > 0 && q_dir[j][q_head[j]] == dir_e'(o + 1)
						&& cyc - q_cyc[j][q_head[j]] >= 4) begin
					rival[o] = 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			cyc <= 0;
			for (int i = 0; i < `N_IN; i++) begin
				q_head[i] <= 0;
				q_cnt[i]  <= 0;
				for (int o = 0; o < `N_OUT; o++) begin
					last_seq[i][o] <= -1;
				end
			end
			for (int o = 0; o < `N_OUT; o++) begin
				last_src[o] <= -1;
				run_len[o]  <= 0;
			end
		end else begin
			cyc <= cyc + 1;
			for (int i = 0; i < `N_IN; i++) begin
				if (in_valid[i] && in_ready[i]) begin
					q_dir[i][(q_head[i] + q_cnt[i]) % qd] <= expect_dir(in_flit[i]);
					q_cyc[i][(q_head[i] + q_cnt[i]) % qd] <= cyc;
				end
				// each input drains in order, one flit per cycle at most
				if (popped[i]) begin
					q_head[i] <= (q_head[i] + 1) % qd;
				end
				q_cnt[i] <= q_cnt[i] + int'(in_valid[i] && in_ready[i]) - int'(popped[i]);
			end
			for (int o = 0; o < `N_OUT; o++) begin
				if (out_valid[o]) begin
					last_seq[src_of(out_flit[o])][o] <= int'(out_flit[o][15:0]);
					run_len[o]  <= (src_of(out_flit[o]) == last_src[o]) ? run_len[o] + 1 : 1;
					last_src[o] <= src_of(out_flit[o]);
				end
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// properties
	//////////////////////////////////////////////////////////////////////

	// outputs idle and inputs open in reset and the cycle after
	a_reset: assert property (@(posedge clk)
			$past(rst) |-> (out_valid == '0) && (in_ready == '1))
		else flag("reset state wrong");

	for (genvar o = 0; o < `N_OUT; o++) begin : g_out
		a_route: assert property (@(posedge clk) disable iff (rst)
				out_valid[o] |-> expect_dir(out_flit[o]) == dir_e'(o + 1))
			else flag("flit left on the wrong output");
		a_valid: assert property (@(posedge clk) disable iff (rst)
				out_valid[o] |-> out_flit[o][`VALID_POS])
			else flag("delivered flit has valid bit clear");
		a_order: assert property (@(posedge clk) disable iff (rst)
				out_valid[o] |-> in_order[o])
			else flag("sequence number out of order");
		// third win in a row while a rival head waits
		a_fair: assert property (@(posedge clk) disable iff (rst)
				(out_valid[o] && src_of(out_flit[o]) == last_src[o] && run_len[o] >= 2)
				|-> !rival[o])
			else flag("round robin skipped a waiting input");
	end

	for (genvar i = 0; i < `N_IN; i++) begin : g_in
		a_depth: assert property (@(posedge clk) disable iff (rst)
				q_cnt[i] <= `FIFO_DEPTH + 2)
			else flag("too many flits in flight on one input");
		a_ready: assert property (@(posedge clk) disable iff (rst)
				q_cnt[i] > `FIFO_DEPTH |-> !in_ready[i])
			else flag("in_ready still high near overflow");
	end

endmodule

bind noc_router noc_router_assert #(
	.cur_x(cur_x),
	.cur_y(cur_y),
	.cur_z(cur_z)
) i_assert (
	.clk       (clk),
	.rst       (rst),
	.in_valid  (in_valid),
	.in_flit   (in_flit),
	.in_ready  (in_ready),
	.out_valid (out_valid),
	.out_flit  (out_flit)
);

/* noc_router_tb.sv */
`include "noc_defs.svh"

module noc_router_tb
	import noc_flit_pkg::*;
();

	// test lengths in cycles, they size the watchdog
	localparam int len_reset = 17;
	localparam int len_directed = 20;
	localparam int len_random = 201;
	localparam int len_fair = 41;
	localparam int len_press = 41;
	localparam int watchdog_time =
		2 * 8 * (len_reset + len_directed + len_random + len_fair + len_press);

	// x, y, z of each directed target, node sits at (1,2,3)
	localparam logic [5:0] dests [10] = '{
		{2'd2, 2'd2, 2'd3},
		{2'd0, 2'd2, 2'd3},
		{2'd3, 2'd2, 2'd3},
		{2'd1, 2'd3, 2'd3},
		{2'd1, 2'd1, 2'd3},
		{2'd1, 2'd0, 2'd3},
		{2'd1, 2'd2, 2'd0},
		{2'd1, 2'd2, 2'd2},
		{2'd1, 2'd2, 2'd1},
		{2'd1, 2'd2, 2'd3}
	};

	logic              clk;
	logic              rst;
	logic [`N_IN-1:0]  in_valid;
	flit_t             in_flit [`N_IN];
	logic [`N_IN-1:0]  in_ready;
	logic [`N_OUT-1:0] out_valid;
	flit_t             out_flit [`N_OUT];

	int seed;
	int seq [`N_IN] = '{default: 0};
	int n_acc = 0;
	int n_del = 0;
	int n_pass = 0;
	int n_fail = 0;
	int fail_seen = 0;

	noc_router #(
		.cur_x(1),
		.cur_y(2),
		.cur_z(3)
	) i_dut (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (in_valid),
		.in_flit   (in_flit),
		.in_ready  (in_ready),
		.out_valid (out_valid),
		.out_flit  (out_flit)
	);

	always #4 clk = ~clk;

	// count accepts and deliveries mid cycle where both are stable
	always @(negedge clk) begin
		if (!rst) begin
			for (int i = 0; i < `N_IN; i++) begin
				if (in_valid[i] && in_ready[i]) begin
					seq[i] = seq[i] + 1;
					n_acc++;
				end
			end
			for (int o = 0; o < `N_OUT; o++) begin
				if (out_valid[o]) begin
					n_del++;
				end
			end
		end
	end

	// source input in bits 30:28, running count in the low half
	function automatic flit_t make_flit(input int i, input int s, input logic [5:0] d);
		flit_t f;
		f = '0;
		f[30:28] = 3'(i);
		f[15:0] = 16'(s);
		f[`DST_X_POS +: `COORD_W] = {1'b0, d[5:4]};
		f[`DST_Y_POS +: `COORD_W] = {1'b0, d[3:2]};
		f[`DST_Z_POS +: `COORD_W] = {1'b0, d[1:0]};
		f[`VALID_POS] = 1'b1;
		return f;
	endfunction

	// valid held regardless of ready unless rnd picks it per cycle
	task automatic drive(input int cycles, input logic [`N_IN-1:0] mask, input logic rnd,
			input logic [5:0] dst);
		logic [31:0] r;
		for (int c = 0; c < cycles; c++) begin
			@(posedge clk);
			#1;
			for (int i = 0; i < `N_IN; i++) begin
				r = $random(seed);
				in_valid[i] = mask[i] && (!rnd || r[8]);
				in_flit[i] = make_flit(i, seq[i], rnd ? r[5:0] : dst);
			end
		end
		@(posedge clk);
		#1;
		in_valid = '0;
	endtask

	// drain, then count assertion failures seen during the test
	task automatic end_test(input string name);
		int errs;
		@(posedge clk);
		while (n_acc != n_del) begin
			@(posedge clk);
		end
		@(posedge clk);
		#1;
		errs = i_dut.i_assert.fail_cnt - fail_seen;
		fail_seen = i_dut.i_assert.fail_cnt;
		if (errs == 0) begin
			n_pass++;
			$display("%0t test %s passed", $time, name);
		end else begin
			n_fail++;
			$display("FAILED %0t test %s saw %0d assertion failures", $time, name, errs);
		end
	endtask

	initial begin
		logic [`N_IN-1:0] one_hot;
		clk = 1'b0;
		rst = 1'b1;
		in_valid = '0;
		seed = 32'h1430;
		for (int i = 0; i < `N_IN; i++) begin
			in_flit[i] = '0;
		end
		repeat (16) @(posedge clk);
		#1;
		rst = 1'b0;
		@(posedge clk);
		end_test("reset");
		// one flit per direction plus ties and eject, spread over inputs
		for (int k = 0; k < 10; k++) begin
			one_hot = '0;
			one_hot[k % `N_IN] = 1'b1;
			drive(1, one_hot, 1'b0, dests[k]);
		end
		end_test("directed routes");
		drive(len_random - 1, '1, 1'b1, '0);
		end_test("random traffic");
		// three inputs fight for eject
		drive(len_fair - 1, 7'b0001110, 1'b0, {2'd1, 2'd2, 2'd3});
		end_test("eject fairness");
		// every input into xpos
		drive(len_press - 1, '1, 1'b0, {2'd2, 2'd2, 2'd3});
		end_test("back-pressure");
		$display("%0d tests passed, %0d tests failed", n_pass, n_fail);
		if (n_fail == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

	initial begin
		#(watchdog_time);
		$display("watchdog expired, the tests did not finish in time");
		$display("TEST FAIL");
		$finish;
	end

endmodule

/* route_comp.sv */
`include "noc_defs.svh"

module route_comp
	import noc_flit_pkg::*;
#(
	parameter int cur_x = 0,
	parameter int cur_y = 0,
	parameter int cur_z = 0
) (
	input  logic  clk,
	input  logic  rst,
	input  logic  flit_valid,
	input  flit_t flit_in,
	output logic  flit_valid_out,
	output flit_t flit_out,
	output dir_e  dir_out
);

	coord_t dst_x;
	coord_t dst_y;
	coord_t dst_z;
	dir_e   dir_next;

	// pick the short way round one ring
	// a tie at half the ring goes positive
	function automatic dir_e ring_dir(input int cur, input coord_t dst, input int size,
			input dir_e pos, input dir_e neg);
		int fwd;
		// hops needed going the positive way
		fwd = (int'(dst) - cur + size) % size;
		if (fwd <= size / 2) begin
			return pos;
		end
		return neg;
	endfunction

	assign dst_x = flit_in[`DST_X_POS +: `DST_X_W];
	assign dst_y = flit_in[`DST_Y_POS +: `DST_Y_W];
	assign dst_z = flit_in[`DST_Z_POS +: `DST_Z_W];

	////////////////////////////////////////////////////////////////////////
	// dimension order routing, x then y then z
	////////////////////////////////////////////////////////////////////////

	always_comb begin
		if (int'(dst_x) != cur_x) begin
			dir_next = ring_dir(cur_x, dst_x, `XSIZE, dir_xpos, dir_xneg);
		end else if (int'(dst_y) != cur_y) begin
			dir_next = ring_dir(cur_y, dst_y, `YSIZE, dir_ypos, dir_yneg);
		end else if (int'(dst_z) != cur_z) begin
			dir_next = ring_dir(cur_z, dst_z, `ZSIZE, dir_zpos, dir_zneg);
		end else begin
			// arrived
			dir_next = dir_eject;
		end
	end

	// valid strobe, one cycle behind the accept
	always_ff @(posedge clk) begin
		if (rst) begin
			flit_valid_out <= 1'b0;
		end else begin
			flit_valid_out <= flit_valid;
		end
	end

	// flit and route held until the next accepted flit
	always_ff @(posedge clk) begin
		if (flit_valid) begin
			flit_out <= flit_in;
			dir_out  <= dir_next;
		end
	end

endmodule

/* run.sh */
#!/bin/sh
# build and run the router testbench with verilator
verilator --binary --assert -Wno-fatal --top-module noc_router_tb -f flist.f -o noc_router_sim \
	|| { echo "build failed"; exit 1; }
./obj_dir/noc_router_sim +verilator+error+limit+1000 > sim.log 2>&1
grep -q "TEST FAIL" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q "TEST PASS" sim.log || { echo "no result found in sim.log"; exit 1; }
echo "simulation passed"

/* switch_ctrl.sv */
`include "noc_defs.svh"

module switch_ctrl
	import noc_flit_pkg::*;
	import noc_arb_pkg::*;
(
	input  logic              clk,
	input  logic              rst,
	input  req_vec_t          head_valid,
	input  dir_e              head_dir [`N_IN],
	output gnt_vec_t          pop,
	output logic [`N_OUT-1:0] out_go,
	output osel_t             out_sel
);

	// round robin pointer per output
	port_idx_t rr_ptr [`N_OUT];
	// request matrix, one row per output
	req_vec_t  req [`N_OUT];

	// first requester at or after ptr, wrapping around
	// msb of the result is the hit flag
	function automatic logic [`PORT_IDX_W:0] pick(input req_vec_t r, input port_idx_t ptr);
		int        idx;
		logic      hit;
		port_idx_t win;
		hit = 1'b0;
		win = '0;
		for (int k = 0; k < `N_IN; k++) begin
			idx = (int'(ptr) + k) % `N_IN;
			if (!hit && r[idx]) begin
				hit = 1'b1;
				win = port_idx_t'(idx);
			end
		end
		return {hit, win};
	endfunction

	////////////////////////////////////////////////////////////////////////
	// requests
	////////////////////////////////////////////////////////////////////////

	// output o serves direction o+1
	always_comb begin
		for (int o = 0; o < `N_OUT; o++) begin
			for (int i = 0; i < `N_IN; i++) begin
				req[o][i] = head_valid[i] && (head_dir[i] == dir_e'(o + 1));
			end
		end
	end

	////////////////////////////////////////////////////////////////////////
	// grants
	////////////////////////////////////////////////////////////////////////

	// each output arbitrates on its own
	for (genvar o = 0; o < `N_OUT; o++) begin : g_out
		assign {out_go[o], out_sel[o]} = pick(req[o], rr_ptr[o]);
	end

	// pop goes back to the winning fifo
	// an input asks one output only so at most one grant lands
	always_comb begin
		pop = '0;
		for (int o = 0; o < `N_OUT; o++) begin
			if (out_go[o]) begin
				pop[out_sel[o]] = 1'b1;
			end
		end
	end

	// pointer moves just past the winner
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int o = 0; o < `N_OUT; o++) begin
				rr_ptr[o] <= '0;
			end
		end else begin
			for (int o = 0; o < `N_OUT; o++) begin
				if (out_go[o]) begin
					if (out_sel[o] == port_idx_t'(`N_IN - 1)) begin
						rr_ptr[o] <= '0;
					end else begin
						rr_ptr[o] <= out_sel[o] + 1'b1;
					end
				end
			end
		end
	end

endmodule
